//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - verilog/fetch_pkg.sv
  - verilog/fetch_ifs.sv
  - verilog/pc_gen.sv
  - verilog/itlb.sv
  - verilog/addr_xlate.sv
  - verilog/ifetch_wb_master.sv
  - verilog/fetch_top.sv
  - target: test
    files:
      - tb/tb_fetch_top.sv

//--- filelist.f
verilog/fetch_pkg.sv
verilog/fetch_ifs.sv
verilog/pc_gen.sv
verilog/itlb.sv
verilog/addr_xlate.sv
verilog/ifetch_wb_master.sv
verilog/fetch_top.sv
tb/tb_fetch_top.sv

//--- tb/fetch_tests.txt
# all values hex, comment lines start with a lone #
# csr da pg plv dmw0 dmw1 eentry tlbrentry era
# tlb index vppn ppn v plv
# redir flags target (flags 1 branch, 2 ertn, 4 excp, 8 tlbrefill)
# busredir flags target (waits for an open bus cycle first)
# expect count stall
# direct mode from reset
csr 1 0 0 0 0 1c008000 1c00f000 1c004000
expect 4 0
# dmw0 at plv0, dmw1 at plv3
csr 0 1 0 82000001 a0000008 1c008000 1c00f000 1c004000
redir 1 80001000
expect 3 0
csr 0 1 3 82000001 a0000008 1c008000 1c00f000 1c004000
redir 1 a0002000
expect 2 0
# tlb paths
tlb 0 00010 00321 1 3
tlb 1 00011 00400 1 0
tlb 2 00012 00500 0 3
csr 0 1 0 82000001 a0000008 1c008000 1c00f000 1c004000
redir 1 00010ff0
expect 4 0
csr 0 1 3 82000001 a0000008 1c008000 1c00f000 1c004000
redir 1 00011000
expect 1 0
redir 1 00012000
expect 1 0
redir 1 00013000
expect 2 0
redir 1 80003000
expect 1 0
redir 1 00010002
expect 2 0
# redirect priority
csr 1 0 0 0 0 1c008000 1c00f000 1c004000
redir f 1c0a0000
expect 2 0
redir 7 1c0a0000
expect 1 0
redir 3 1c0a0000
expect 1 0
redir 1 1c0a0004
expect 2 0
# back-pressure and redirects during a bus cycle
expect 12 1
busredir 1 1c0b0000
expect 3 1
busredir 7 00000000
expect 2 1

//--- tb/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int TLB_N = 8;
    localparam int CYCLES_PER_BUNDLE = 40;
    localparam int CYCLES_PER_LINE = 20;
    localparam logic [31:0] DATA_KEY = 32'ha5a5_0000;
    localparam TEST_FILE = "tb/fetch_tests.txt";

    logic        clk;
    logic        rst;
    logic        branch_valid;
    logic [31:0] branch_target;
    logic        excp_flush;
    logic        tlbrefill;
    logic        ertn_flush;
    logic        csr_da;
    logic        csr_pg;
    logic [1:0]  csr_plv;
    logic [31:0] csr_dmw0;
    logic [31:0] csr_dmw1;
    logic [31:0] csr_eentry;
    logic [31:0] csr_tlbrentry;
    logic [31:0] csr_era;
    logic        tlb_we;
    logic [2:0]  tlb_index;
    logic [19:0] tlb_vppn;
    logic [19:0] tlb_ppn;
    logic        tlb_v;
    logic [1:0]  tlb_plv;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [7:0]  wb_sel;
    logic        wb_ack;
    logic [63:0] wb_dat_i;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_inst0;
    logic [31:0] out_inst1;
    logic [1:0]  out_slot_mask;
    logic [2:0]  out_excp;
    logic        out_ready;

    // reference copy of the itlb
    logic        ref_present [TLB_N];
    logic [19:0] ref_vppn [TLB_N];
    logic [19:0] ref_ppn [TLB_N];
    logic        ref_v [TLB_N];
    logic [1:0]  ref_plv [TLB_N];

    logic [31:0] exp_pc;
    logic [31:0] start_adr;
    logic [7:0]  start_sel;
    logic        start_we;
    logic [31:0] arg [8];
    logic        mem_busy;
    int unsigned wait_left;
    int unsigned bus_starts = 0;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    fetch_top #(
        .ITLB_ENTRIES (TLB_N)
    ) fetch_top_inst (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped delivering bundles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // wishbone memory, 0 to 3 wait states per cycle
    always @(posedge clk) begin
        logic [31:0] base;
        if (rst) begin
            mem_busy = 1'b0;
            #1;
            wb_ack = 1'b0;
        end else if (wb_ack) begin
            #1;
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                wait_left = $urandom % 4;
                bus_starts = bus_starts + 1;
                start_adr = wb_adr;
                start_sel = wb_sel;
                start_we = wb_we;
            end
            if (wait_left == 0) begin
                base = wb_adr;
                mem_busy = 1'b0;
                #1;
                wb_ack = 1'b1;
                wb_dat_i = {(base + 32'd4) ^ DATA_KEY, base ^ DATA_KEY};
            end else begin
                wait_left = wait_left - 1;
            end
        end else if (wb_cyc || wb_stb || mem_busy) begin
            // cyc and stb rise together and hold until the ack
            errors++;
            $display("wishbone cycle at %h broken before its ack, cyc %b stb %b",
                     start_adr, wb_cyc, wb_stb);
            mem_busy = 1'b0;
        end
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h in test %0d", name, got, exp, tests);
        end
    endtask

    function automatic logic window_hit(input logic [31:0] dmw, input logic [31:0] va);
        logic plv_en;
        plv_en = (csr_plv == 2'd0) ? dmw[0] : (csr_plv == 2'd3) ? dmw[3] : 1'b0;
        return plv_en && (va[31:29] == dmw[31:29]);
    endfunction

    task automatic translate_pc(input logic [31:0] va, output logic [31:0] pa,
                                output logic [2:0] excp);
        logic found;
        int   idx;
        found = 1'b0;
        idx = 0;
        pa = va;
        excp = EXCP_NONE;
        if (!csr_da && csr_pg) begin
            if (window_hit(csr_dmw0, va)) begin
                pa = {csr_dmw0[27:25], va[28:0]};
            end else if (window_hit(csr_dmw1, va)) begin
                pa = {csr_dmw1[27:25], va[28:0]};
            end else begin
                for (int i = 0; i < TLB_N; i++) begin
                    if (!found && ref_present[i] && ref_vppn[i] == va[31:12]) begin
                        found = 1'b1;
                        idx = i;
                    end
                end
                pa = {ref_ppn[idx], va[11:0]};
                if (va[31] && csr_plv == 2'd3) begin
                    excp = EXCP_ADEF;
                end else if (!found) begin
                    excp = EXCP_TLBR;
                end else if (!ref_v[idx]) begin
                    excp = EXCP_PIF;
                end else if (csr_plv > ref_plv[idx]) begin
                    excp = EXCP_PPI;
                end
            end
        end
        // misaligned fetch faults on every path
        if (va[1:0] != 2'b00) begin
            excp = EXCP_ADEF;
        end
    endtask

    task automatic check_bundle();
        logic [31:0] pa;
        logic [31:0] base;
        logic [2:0]  excp;
        translate_pc(exp_pc, pa, excp);
        base = pa & 32'hffff_fff8;
        check_field("out_pc", out_pc, exp_pc);
        check_field("out_slot_mask", out_slot_mask, exp_pc[2] ? 2'b10 : 2'b11);
        check_field("out_excp", out_excp, excp);
        checks++;
        if (excp == EXCP_NONE) begin
            if (bus_starts != 1) begin
                errors++;
                $display("test %0d: pc %h made %0d bus cycles instead of one",
                         tests, exp_pc, bus_starts);
            end
            check_field("wb_adr", start_adr, base);
            check_field("wb_sel", start_sel, 8'hff);
            check_field("wb_we", start_we, 1'b0);
            check_field("out_inst0", out_inst0, base ^ DATA_KEY);
            check_field("out_inst1", out_inst1, (base + 32'd4) ^ DATA_KEY);
        end else if (bus_starts != 0) begin
            errors++;
            $display("test %0d: faulting pc %h still started a bus cycle", tests, exp_pc);
        end
    endtask

    task automatic run_expect(input int unsigned count, input logic stall);
        int unsigned got;
        int          err_before;
        logic        held;
        logic [31:0] h_pc;
        logic [31:0] h_inst0;
        logic [31:0] h_inst1;
        logic [4:0]  h_tag;
        got = 0;
        held = 1'b0;
        err_before = errors;
        tests++;
        out_ready = stall ? ($urandom % 3 == 0) : 1'b1;
        while (got < count) begin
            @(posedge clk);
            if (out_valid) begin
                if (!held) begin
                    held = 1'b1;
                    h_pc = out_pc;
                    h_inst0 = out_inst0;
                    h_inst1 = out_inst1;
                    h_tag = {out_slot_mask, out_excp};
                end else begin
                    check_field("out_pc (held)", out_pc, h_pc);
                    check_field("out_inst0 (held)", out_inst0, h_inst0);
                    check_field("out_inst1 (held)", out_inst1, h_inst1);
                    check_field("out_slot_mask/out_excp (held)",
                                {out_slot_mask, out_excp}, h_tag);
                end
                if (out_ready) begin
                    check_bundle();
                    got++;
                    held = 1'b0;
                    exp_pc = (exp_pc & 32'hffff_fff8) + 32'd8;
                    bus_starts = 0;
                end
            end
            #1;
            if (got < count) begin
                out_ready = stall ? ($urandom % 3 == 0) : 1'b1;
            end else begin
                out_ready = 1'b0;
            end
        end
        $display("test %0d: %0d bundles, %0d errors", tests, count, errors - err_before);
    endtask

    task automatic apply_redirect(input logic [3:0] flags, input logic [31:0] target,
                                  input logic on_bus);
        if (on_bus) begin
            while (!wb_cyc) begin
                @(posedge clk);
                #1;
            end
        end
        branch_valid = flags[0];
        ertn_flush = flags[1];
        excp_flush = flags[2];
        tlbrefill = flags[3];
        branch_target = target;
        if (flags[2]) begin
            exp_pc = flags[3] ? csr_tlbrentry : csr_eentry;
        end else if (flags[1]) begin
            exp_pc = csr_era;
        end else begin
            exp_pc = target;
        end
        @(posedge clk);
        #1;
        branch_valid = 1'b0;
        ertn_flush = 1'b0;
        excp_flush = 1'b0;
        tlbrefill = 1'b0;
        // an open bus cycle still completes, its data belongs to the old pc
        while (wb_cyc) begin
            @(posedge clk);
            #1;
        end
        bus_starts = 0;
    endtask

    task automatic write_tlb();
        tlb_we = 1'b1;
        tlb_index = arg[0][2:0];
        tlb_vppn = arg[1][19:0];
        tlb_ppn = arg[2][19:0];
        tlb_v = arg[3][0];
        tlb_plv = arg[4][1:0];
        ref_present[arg[0][2:0]] = 1'b1;
        ref_vppn[arg[0][2:0]] = arg[1][19:0];
        ref_ppn[arg[0][2:0]] = arg[2][19:0];
        ref_v[arg[0][2:0]] = arg[3][0];
        ref_plv[arg[0][2:0]] = arg[4][1:0];
        @(posedge clk);
        #1;
        tlb_we = 1'b0;
    endtask

    initial begin
        int               fd;
        int               r;
        int unsigned      seed;
        int unsigned      bundles;
        int unsigned      lines;
        logic [8*16-1:0]  cmd;
        logic [8*128-1:0] rest;
        seed = 32'h860d;
        r = $urandom(seed);
        clk = 1'b0;
        rst = 1'b1;
        branch_valid = 1'b0;
        branch_target = '0;
        excp_flush = 1'b0;
        tlbrefill = 1'b0;
        ertn_flush = 1'b0;
        csr_da = 1'b1;
        csr_pg = 1'b0;
        csr_plv = 2'd0;
        csr_dmw0 = '0;
        csr_dmw1 = '0;
        csr_eentry = '0;
        csr_tlbrentry = '0;
        csr_era = '0;
        tlb_we = 1'b0;
        tlb_index = '0;
        tlb_vppn = '0;
        tlb_ppn = '0;
        tlb_v = 1'b0;
        tlb_plv = 2'd0;
        wb_ack = 1'b0;
        wb_dat_i = '0;
        out_ready = 1'b0;
        exp_pc = RESET_PC;
        for (int i = 0; i < TLB_N; i++) begin
            ref_present[i] = 1'b0;
        end

        // first pass sizes the timeout
        bundles = 0;
        lines = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the test vector file");
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "expect") begin
                    r = $fscanf(fd, "%h %h", arg[0], arg[1]);
                    bundles = bundles + arg[0];
                end else begin
                    r = $fgets(rest, fd);
                end
                lines++;
            end
            $fclose(fd);
        end
        cycle_limit = CYCLES_PER_BUNDLE * bundles + CYCLES_PER_LINE * lines + 20;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_field("wb_cyc", wb_cyc, 1'b0);
        check_field("wb_stb", wb_stb, 1'b0);
        check_field("wb_we", wb_we, 1'b0);
        check_field("out_valid", out_valid, 1'b0);

        fd = $fopen(TEST_FILE, "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    r = $fgets(rest, fd);
                end else if (cmd == "csr") begin
                    r = $fscanf(fd, "%h %h %h %h %h %h %h %h", arg[0], arg[1], arg[2],
                                arg[3], arg[4], arg[5], arg[6], arg[7]);
                    csr_da = arg[0][0];
                    csr_pg = arg[1][0];
                    csr_plv = arg[2][1:0];
                    csr_dmw0 = arg[3];
                    csr_dmw1 = arg[4];
                    csr_eentry = arg[5];
                    csr_tlbrentry = arg[6];
                    csr_era = arg[7];
                end else if (cmd == "tlb") begin
                    r = $fscanf(fd, "%h %h %h %h %h", arg[0], arg[1], arg[2], arg[3],
                                arg[4]);
                    write_tlb();
                end else if (cmd == "redir" || cmd == "busredir") begin
                    r = $fscanf(fd, "%h %h", arg[0], arg[1]);
                    apply_redirect(arg[0][3:0], arg[1], cmd == "busredir");
                end else if (cmd == "expect") begin
                    r = $fscanf(fd, "%h %h", arg[0], arg[1]);
                    run_expect(arg[0], arg[1][0]);
                end else begin
                    errors++;
                    $display("unknown command in the test vector file");
                    r = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog/addr_xlate.sv
`timescale 1ns/1ps

module addr_xlate (
    input  fetch_pkg::addr_t pc,
    input  logic             pc_valid,
    input  logic             csr_da,
    input  logic             csr_pg,
    input  fetch_pkg::plv_t  csr_plv,
    input  logic [31:0]      csr_dmw0,
    input  logic [31:0]      csr_dmw1,
    tlb_lookup_if.requester  tlb,
    xlate_req_if.source      req
);
    import fetch_pkg::*;

    logic dmw0_hit;
    logic dmw1_hit;
    logic paging;
    logic tlb_path;
    logic misaligned;

    function automatic logic dmw_match(
        input logic [31:0] dmw,
        input plv_t        plv,
        input addr_t       va
    );
        logic plv_ok;
        plv_ok = (dmw[DMW_PLV0_BIT] && plv == 2'd0) || (dmw[DMW_PLV3_BIT] && plv == 2'd3);
        return plv_ok && (va[31:29] == dmw[DMW_VSEG_LSB +: 3]);
    endfunction

    assign paging   = csr_pg && !csr_da;
    assign dmw0_hit = paging && dmw_match(csr_dmw0, csr_plv, pc);
    assign dmw1_hit = paging && !dmw0_hit && dmw_match(csr_dmw1, csr_plv, pc);
    assign tlb_path = paging && !dmw0_hit && !dmw1_hit;

    assign misaligned = pc[1:0] != 2'b00;

    assign tlb.vppn = pc[31:PAGE_BITS];

    always_comb begin
        if (dmw0_hit) begin
            req.pa = {csr_dmw0[DMW_PSEG_LSB +: 3], pc[28:0]};
        end else if (dmw1_hit) begin
            req.pa = {csr_dmw1[DMW_PSEG_LSB +: 3], pc[28:0]};
        end else if (tlb_path) begin
            req.pa = {tlb.ppn, pc[PAGE_BITS-1:0]};
        end else begin
            // direct mode
            req.pa = pc;
        end
    end

    // fault priority: ADEF, TLBR, PIF, PPI
    always_comb begin
        req.excp = EXCP_NONE;
        if (misaligned) begin
            req.excp = EXCP_ADEF;
        end else if (tlb_path) begin
            if (pc[31] && csr_plv == 2'd3) begin
                req.excp = EXCP_ADEF;
            end else if (!tlb.hit) begin
                req.excp = EXCP_TLBR;
            end else if (!tlb.v) begin
                req.excp = EXCP_PIF;
            end else if (csr_plv > tlb.plv) begin
                req.excp = EXCP_PPI;
            end
        end
    end

    assign req.valid = pc_valid;
    assign req.va    = pc;
    // only the second slot is live for a 4-odd pc
    assign req.slot_mask = pc[2] ? 2'b10 : 2'b11;

endmodule

//--- verilog/fetch_ifs.sv
`timescale 1ns/1ps

// itlb lookup, answered in the same cycle
interface tlb_lookup_if;
    import fetch_pkg::*;

    logic [VPPN_W-1:0] vppn;
    logic              hit;
    logic              v;
    plv_t              plv;
    logic [VPPN_W-1:0] ppn;

    modport requester (output vppn, input hit, v, plv, ppn);
    modport responder (input vppn, output hit, v, plv, ppn);
endinterface

// translated fetch request, taken when valid && take
interface xlate_req_if;
    import fetch_pkg::*;

    logic        valid;
    addr_t       va;
    addr_t       pa;
    logic [1:0]  slot_mask;
    fetch_excp_e excp;
    logic        take;

    modport source (output valid, va, pa, slot_mask, excp, input take);
    modport sink (input valid, va, pa, slot_mask, excp, output take);
endinterface

//--- verilog/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [1:0]  plv_t;

    // fetch exception codes, listed in priority order
    typedef enum logic [2:0] {
        EXCP_NONE = 3'd0,
        EXCP_ADEF = 3'd1,
        EXCP_TLBR = 3'd2,
        EXCP_PIF  = 3'd3,
        EXCP_PPI  = 3'd4
    } fetch_excp_e;

    // first fetch address after reset
    localparam addr_t RESET_PC = 32'h1c00_0000;

    // direct-mapping window register fields
    localparam int DMW_PLV0_BIT = 0;
    localparam int DMW_PLV3_BIT = 3;
    // 3-bit segments, given by their low bit
    localparam int DMW_PSEG_LSB = 25;
    localparam int DMW_VSEG_LSB = 29;

    // 4 KB pages
    localparam int PAGE_BITS = 12;
    localparam int VPPN_W    = 20;

endpackage

//--- verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int ITLB_ENTRIES = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              branch_valid,
    input  fetch_pkg::addr_t                  branch_target,
    input  logic                              excp_flush,
    input  logic                              tlbrefill,
    input  logic                              ertn_flush,
    input  logic                              csr_da,
    input  logic                              csr_pg,
    input  fetch_pkg::plv_t                   csr_plv,
    input  logic [31:0]                       csr_dmw0,
    input  logic [31:0]                       csr_dmw1,
    input  fetch_pkg::addr_t                  csr_eentry,
    input  fetch_pkg::addr_t                  csr_tlbrentry,
    input  fetch_pkg::addr_t                  csr_era,
    input  logic                              tlb_we,
    input  logic [$clog2(ITLB_ENTRIES)-1:0]   tlb_index,
    input  logic [fetch_pkg::VPPN_W-1:0]      tlb_vppn,
    input  logic [fetch_pkg::VPPN_W-1:0]      tlb_ppn,
    input  logic                              tlb_v,
    input  fetch_pkg::plv_t                   tlb_plv,
    output logic                              wb_cyc,
    output logic                              wb_stb,
    output logic                              wb_we,
    output fetch_pkg::addr_t                  wb_adr,
    output logic [7:0]                        wb_sel,
    input  logic                              wb_ack,
    input  logic [63:0]                       wb_dat_i,
    output logic                              out_valid,
    output fetch_pkg::addr_t                  out_pc,
    output fetch_pkg::inst_t                  out_inst0,
    output fetch_pkg::inst_t                  out_inst1,
    output logic [1:0]                        out_slot_mask,
    output fetch_pkg::fetch_excp_e            out_excp,
    input  logic                              out_ready
);
    import fetch_pkg::*;

    addr_t pc;
    logic  pc_valid;
    logic  redirect;
    logic  advance;

    tlb_lookup_if tlb_bus ();
    xlate_req_if  req_bus ();

    pc_gen pc_gen_inst (
        .clk           (clk),
        .rst           (rst),
        .branch_valid  (branch_valid),
        .branch_target (branch_target),
        .excp_flush    (excp_flush),
        .tlbrefill     (tlbrefill),
        .ertn_flush    (ertn_flush),
        .csr_eentry    (csr_eentry),
        .csr_tlbrentry (csr_tlbrentry),
        .csr_era       (csr_era),
        .advance       (advance),
        .pc            (pc),
        .pc_valid      (pc_valid),
        .redirect      (redirect)
    );

    itlb #(
        .ITLB_ENTRIES (ITLB_ENTRIES)
    ) itlb_inst (
        .clk    (clk),
        .rst    (rst),
        .we     (tlb_we),
        .index  (tlb_index),
        .vppn_w (tlb_vppn),
        .ppn_w  (tlb_ppn),
        .v_w    (tlb_v),
        .plv_w  (tlb_plv),
        .lookup (tlb_bus.responder)
    );

    addr_xlate addr_xlate_inst (
        .pc       (pc),
        .pc_valid (pc_valid),
        .csr_da   (csr_da),
        .csr_pg   (csr_pg),
        .csr_plv  (csr_plv),
        .csr_dmw0 (csr_dmw0),
        .csr_dmw1 (csr_dmw1),
        .tlb      (tlb_bus.requester),
        .req      (req_bus.source)
    );

    ifetch_wb_master ifetch_wb_master_inst (
        .clk           (clk),
        .rst           (rst),
        .req           (req_bus.sink),
        .redirect      (redirect),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_sel        (wb_sel),
        .wb_ack        (wb_ack),
        .wb_dat_i      (wb_dat_i),
        .out_valid     (out_valid),
        .out_pc        (out_pc),
        .out_inst0     (out_inst0),
        .out_inst1     (out_inst1),
        .out_slot_mask (out_slot_mask),
        .out_excp      (out_excp),
        .out_ready     (out_ready),
        .advance       (advance)
    );

endmodule

//--- verilog/ifetch_wb_master.sv
`timescale 1ns/1ps

module ifetch_wb_master (
    input  logic                  clk,
    input  logic                  rst,
    xlate_req_if.sink             req,
    input  logic                  redirect,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output fetch_pkg::addr_t      wb_adr,
    output logic [7:0]            wb_sel,
    input  logic                  wb_ack,
    input  logic [63:0]           wb_dat_i,
    output logic                  out_valid,
    output fetch_pkg::addr_t      out_pc,
    output fetch_pkg::inst_t      out_inst0,
    output fetch_pkg::inst_t      out_inst1,
    output logic [1:0]            out_slot_mask,
    output fetch_pkg::fetch_excp_e out_excp,
    input  logic                  out_ready,
    output logic                  advance
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_HOLD
    } state_e;

    state_e state;
    logic   discard;
    logic   taken;

    // no new request while a redirect is changing the pc
    assign req.take = (state == ST_IDLE) && !redirect;
    assign taken    = req.valid && req.take;

    assign wb_cyc = (state == ST_BUS);
    assign wb_stb = (state == ST_BUS);
    assign wb_we  = 1'b0;
    assign wb_sel = 8'hff;

    assign out_valid = (state == ST_HOLD);
    assign advance   = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            discard <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (taken) begin
                        state <= (req.excp != EXCP_NONE) ? ST_HOLD : ST_BUS;
                    end
                end
                ST_BUS: begin
                    // the bus cycle always finishes, stale data is dropped
                    if (wb_ack) begin
                        state   <= (discard || redirect) ? ST_IDLE : ST_HOLD;
                        discard <= 1'b0;
                    end else if (redirect) begin
                        discard <= 1'b1;
                    end
                end
                ST_HOLD: begin
                    if (redirect || out_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // bundle and bus address
    always_ff @(posedge clk) begin
        if (taken) begin
            out_pc        <= req.va;
            out_slot_mask <= req.slot_mask;
            out_excp      <= req.excp;
            out_inst0     <= '0;
            out_inst1     <= '0;
            wb_adr        <= {req.pa[31:3], 3'b000};
        end else if (state == ST_BUS && wb_ack) begin
            out_inst0 <= wb_dat_i[31:0];
            out_inst1 <= wb_dat_i[63:32];
        end
    end

    a_stb_until_ack: assert property (
        @(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> wb_stb
    ) else $error("ifetch_wb_master: stb dropped before ack");

    // the slave only acks an open cycle
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |-> wb_stb
    ) else $error("ifetch_wb_master: ack without an open bus cycle");

endmodule

//--- verilog/itlb.sv
`timescale 1ns/1ps

module itlb #(
    parameter int ITLB_ENTRIES = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                we,
    input  logic [$clog2(ITLB_ENTRIES)-1:0]     index,
    input  logic [fetch_pkg::VPPN_W-1:0]        vppn_w,
    input  logic [fetch_pkg::VPPN_W-1:0]        ppn_w,
    input  logic                                v_w,
    input  fetch_pkg::plv_t                     plv_w,
    tlb_lookup_if.responder                     lookup
);
    import fetch_pkg::*;

    logic [ITLB_ENTRIES-1:0] present;
    logic [VPPN_W-1:0]       vppn_q [ITLB_ENTRIES];
    logic [VPPN_W-1:0]       ppn_q  [ITLB_ENTRIES];
    logic                    v_q    [ITLB_ENTRIES];
    plv_t                    plv_q  [ITLB_ENTRIES];
    logic                    dup_vppn;

    always_ff @(posedge clk) begin
        if (rst) begin
            present <= '0;
        end else if (we) begin
            present[index] <= 1'b1;
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (we) begin
            vppn_q[index] <= vppn_w;
            ppn_q[index]  <= ppn_w;
            v_q[index]    <= v_w;
            plv_q[index]  <= plv_w;
        end
    end

    // scan downwards so the lowest matching index wins
    always_comb begin
        lookup.hit = 1'b0;
        lookup.v   = 1'b0;
        lookup.plv = '0;
        lookup.ppn = '0;
        for (int i = ITLB_ENTRIES - 1; i >= 0; i--) begin
            if (present[i] && vppn_q[i] == lookup.vppn) begin
                lookup.hit = 1'b1;
                lookup.v   = v_q[i];
                lookup.plv = plv_q[i];
                lookup.ppn = ppn_q[i];
            end
        end
    end

    always_comb begin
        dup_vppn = 1'b0;
        for (int i = 0; i < ITLB_ENTRIES; i++) begin
            for (int j = i + 1; j < ITLB_ENTRIES; j++) begin
                if (present[i] && present[j] && vppn_q[i] == vppn_q[j]) begin
                    dup_vppn = 1'b1;
                end
            end
        end
    end

    // software must not load two entries for one page
    a_no_dup_vppn: assert property (
        @(posedge clk) disable iff (rst)
        !dup_vppn
    ) else $error("itlb: duplicate vppn in present entries");

endmodule

//--- verilog/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  logic             branch_valid,
    input  fetch_pkg::addr_t branch_target,
    input  logic             excp_flush,
    input  logic             tlbrefill,
    input  logic             ertn_flush,
    input  fetch_pkg::addr_t csr_eentry,
    input  fetch_pkg::addr_t csr_tlbrentry,
    input  fetch_pkg::addr_t csr_era,
    input  logic             advance,
    output fetch_pkg::addr_t pc,
    output logic             pc_valid,
    output logic             redirect
);
    import fetch_pkg::*;

    addr_t redirect_target;
    addr_t seq_pc;

    assign redirect = excp_flush | ertn_flush | branch_valid;

    // exception entry first, then ertn, then branch
    always_comb begin
        if (excp_flush) begin
            redirect_target = tlbrefill ? csr_tlbrentry : csr_eentry;
        end else if (ertn_flush) begin
            redirect_target = csr_era;
        end else begin
            redirect_target = branch_target;
        end
    end

    // next aligned pair, a 4-odd pc drops to the pair base first
    assign seq_pc = {pc[31:3] + 29'd1, 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_target;
        end else if (advance) begin
            pc <= seq_pc;
        end
    end

    // one idle cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_valid <= 1'b0;
        end else begin
            pc_valid <= 1'b1;
        end
    end

    // the new target must be fetched before anything steps past it
    a_no_advance_after_redirect: assert property (
        @(posedge clk) disable iff (rst)
        redirect |=> !advance
    ) else $error("pc_gen: advance right after a redirect skips its target");

endmodule
